// File: logic/mcsr_params.svh
// Build options for the CSR block. The counter half width must stay 32
// to match the CSR data path and the 64-bit counter buses.
`ifndef MCSR_PARAMS_SVH
`define MCSR_PARAMS_SVH

`default_nettype none

// ==============================
// Boot and counter options
// ==============================

// Reset value of mtvec, Direct mode so bits [1:0] are ignored
`define MCSR_BOOT_ADDR 32'h0000_0100

// 1 keeps mcycle and minstret, 0 reads them as zero
`define MCSR_EN_COUNTERS 1

// 1 gives full 64-bit counters, 0 reads the upper halves as zero
`define MCSR_EN_COUNTERS64B 1

// Width of one counter half
`define MCSR_CTR_HALF_W 32

`default_nettype wire

`endif

// File: logic/mcsr_pkg.sv
// Machine-mode CSR types only. No user or supervisor level, and no
// vectored trap mode.
`default_nettype none

package mcsr_pkg;

  // ==============================
  // CSR addresses
  // ==============================

  // Standard machine-level addresses
  typedef enum logic [11:0] {
    MSTATUS   = 12'h300,
    MIE       = 12'h304,
    MTVEC     = 12'h305,
    MSCRATCH  = 12'h340,
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    MTVAL     = 12'h343,
    MIP       = 12'h344,
    MCYCLE    = 12'hB00,
    MINSTRET  = 12'hB02,
    MCYCLEH   = 12'hB80,
    MINSTRETH = 12'hB82
  } csr_addr_e;

  // Low two bits of funct3, bit 2 picks the immediate source
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  // ==============================
  // Trap and privilege encodings
  // ==============================

  // mcause codes of the three interrupt sources
  typedef enum logic [3:0] {
    SOFTWARE_INTERRUPT = 4'd3,
    TIMER_INTERRUPT    = 4'd7,
    EXTERNAL_INTERRUPT = 4'd11
  } irq_cause_e;

  // Only machine mode exists
  typedef enum logic [1:0] {
    PRIVILEGE_MACHINE = 2'b11
  } priv_e;

  // mtvec mode field
  localparam logic [1:0] MTVEC_DIRECT = 2'b00;

endpackage

`default_nettype wire

// File: logic/mcsr_counter64.sv
// Two-half counter, upper half lags the lower by one cycle on a wrap.
// Reads must wait for count_vld to see a coherent 64-bit value.
`timescale 1ns/1ps
`include "mcsr_params.svh"
`default_nettype none

module mcsr_counter64 (
  input  logic                            clk,
  input  logic                            rstz,
  input  logic                            incr,
  input  logic [`MCSR_CTR_HALF_W-1:0]     load_data,
  input  logic                            load_low,
  input  logic                            load_high,
  output logic [2*`MCSR_CTR_HALF_W-1:0]   count,
  output logic                            count_vld
);

  localparam int   HW    = `MCSR_CTR_HALF_W;
  localparam logic EN    = 1'(`MCSR_EN_COUNTERS);
  localparam logic EN64B = 1'(`MCSR_EN_COUNTERS64B);

  logic [HW-1:0] count_lo;
  logic [HW-1:0] count_hi;
  logic [HW:0]   lo_sum;
  logic          carry;

  // Lower half plus one, MSB is the carry out
  assign lo_sum = {1'b0, count_lo} + 1'b1;

  // Lower half and registered carry
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      count_lo <= '0;
      carry    <= 1'b0;
    end else begin
      carry <= 1'b0;
      if (load_low) begin
        count_lo <= load_data;
      end else if (incr) begin
        count_lo <= lo_sum[HW-1:0];
        carry    <= lo_sum[HW];
      end
    end
  end

  // Upper half, bumped one cycle after the wrap
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      count_hi <= '0;
    end else if (load_high) begin
      count_hi <= load_data;
    end else if (carry) begin
      count_hi <= count_hi + 1'b1;
    end
  end

  // Option gating on the read side
  assign count     = EN ? {(EN64B ? count_hi : {HW{1'b0}}), count_lo} : {2*HW{1'b0}};
  // Invalid only while a carry is pending
  assign count_vld = EN64B ? ~carry : 1'b1;

endmodule

`default_nettype wire

// File: logic/mcsr_irq.sv
// Level-sensitive sources, held by the source until serviced.
// Cause keeps its last value once mip drops to zero.
`timescale 1ns/1ps
`default_nettype none

module mcsr_irq
  import mcsr_pkg::*;
(
  input  logic       clk,
  input  logic       rstz,
  input  logic       software_interrupt,
  input  logic       timer_interrupt,
  input  logic       external_interrupt,
  input  logic       global_ie,
  input  logic       msie,
  input  logic       mtie,
  input  logic       meie,
  output logic [2:0] mip,
  output logic       core_interrupt,
  output irq_cause_e core_interrupt_cause
);

  // ==============================
  // Pending bits and core flag
  // ==============================

  // mip[0] msip, mip[1] mtip, mip[2] meip
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      mip            <= '0;
      core_interrupt <= 1'b0;
    end else begin
      mip[0]         <= software_interrupt & global_ie & msie;
      mip[1]         <= timer_interrupt & global_ie & mtie;
      mip[2]         <= external_interrupt & global_ie & meie;
      // One cycle behind mip
      core_interrupt <= |mip;
    end
  end

  // Priority: external, software, then timer
  always_ff @(posedge clk) begin
    if (mip[2]) begin
      core_interrupt_cause <= EXTERNAL_INTERRUPT;
    end else if (mip[0]) begin
      core_interrupt_cause <= SOFTWARE_INTERRUPT;
    end else if (mip[1]) begin
      core_interrupt_cause <= TIMER_INTERRUPT;
    end
  end

endmodule

`default_nettype wire

// File: logic/mcsr_file.sv
// Request inputs must stay stable from accept until csr_rdy. Unknown
// addresses read zero and drop writes; no illegal-access trap.
`timescale 1ns/1ps
`include "mcsr_params.svh"
`default_nettype none

module mcsr_file
  import mcsr_pkg::*;
(
  input  logic        clk,
  input  logic        rstz,
  input  logic [31:0] ir,
  input  logic [31:0] op1,
  input  logic [31:0] pc,
  input  logic        is_csr,
  input  logic        csr_vld,
  output logic        csr_rdy,
  output logic [31:0] csr_data,
  output logic        regwr_csr,
  input  logic        activate_trap,
  input  logic        return_trap,
  input  logic [31:0] trap_cause,
  input  logic [31:0] trap_value,
  output logic [31:0] trap_handle,
  output logic        trap_jump,
  input  logic [2:0]  mip,
  output logic        global_ie,
  output logic        msie,
  output logic        mtie,
  output logic        meie,
  input  logic [63:0] mcycle,
  input  logic        mcycle_vld,
  input  logic [63:0] minstret,
  input  logic        minstret_vld,
  output logic [31:0] ctr_load_data,
  output logic        mcycle_load_low,
  output logic        mcycle_load_high,
  output logic        minstret_load_low,
  output logic        minstret_load_high
);

  localparam logic [31:0] BOOT_ADDR = `MCSR_BOOT_ADDR;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE
  } seq_state_e;

  seq_state_e  state;
  seq_state_e  state_nxt;
  logic [11:0] addr;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  zimm;
  csr_op_e     op;
  logic [31:0] src;
  logic        accept;
  logic        rd_ok;
  logic        wr_pend;
  logic        rd_nz;
  logic        wr_en;
  logic [31:0] rd_data;
  logic [31:0] wr_data;
  logic        mstatus_mie;
  logic        mstatus_mpie;
  logic [29:0] mtvec_base;
  logic [31:0] mscratch;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] mtval;

  // ==============================
  // Instruction fields
  // ==============================
  assign addr   = ir[31:20];
  assign zimm   = ir[19:15];
  assign funct3 = ir[14:12];
  assign rd     = ir[11:7];
  assign op     = csr_op_e'(funct3[1:0]);
  // Zero-extended immediate or rs1 value
  assign src    = funct3[2] ? {27'b0, zimm} : op1;

  // ==============================
  // Sequencer
  // ==============================
  assign accept  = state == IDLE && csr_vld && is_csr;
  // Both counters coherent
  assign rd_ok   = mcycle_vld && minstret_vld;
  assign csr_rdy = state == WRITE;
  assign wr_en   = csr_rdy && wr_pend;
  assign regwr_csr = csr_rdy && rd_nz;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (accept) state_nxt = READ;
      READ:    if (rd_ok) state_nxt = WRITE;
      WRITE:   state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      state   <= IDLE;
      wr_pend <= 1'b0;
      rd_nz   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        // Set/clear with a zero mask leaves the CSR alone
        wr_pend <= !((op == CSR_RS || op == CSR_RC) && zimm == 5'd0);
        // No register writeback to x0
        rd_nz   <= rd != 5'd0;
      end
    end
  end

  // Old value captured on the edge leaving READ
  always_ff @(posedge clk) begin
    if (state == READ && rd_ok) csr_data <= rd_data;
  end

  // ==============================
  // Read mux and modify
  // ==============================
  always_comb begin
    rd_data = '0;
    case (addr)
      MSTATUS: begin
        rd_data[3]     = mstatus_mie;
        rd_data[7]     = mstatus_mpie;
        // Hardwired, machine mode only
        rd_data[12:11] = PRIVILEGE_MACHINE;
      end
      MIE: begin
        rd_data[3]  = msie;
        rd_data[7]  = mtie;
        rd_data[11] = meie;
      end
      MIP: begin
        rd_data[3]  = mip[0];
        rd_data[7]  = mip[1];
        rd_data[11] = mip[2];
      end
      // Direct vectors only
      MTVEC:     rd_data = {mtvec_base, MTVEC_DIRECT};
      MSCRATCH:  rd_data = mscratch;
      MEPC:      rd_data = mepc;
      MCAUSE:    rd_data = mcause;
      MTVAL:     rd_data = mtval;
      MCYCLE:    rd_data = mcycle[31:0];
      MCYCLEH:   rd_data = mcycle[63:32];
      MINSTRET:  rd_data = minstret[31:0];
      MINSTRETH: rd_data = minstret[63:32];
      default:   rd_data = '0;
    endcase
  end

  // Set, clear or replace the latched old value
  always_comb begin
    case (op)
      CSR_RS:  wr_data = csr_data | src;
      CSR_RC:  wr_data = csr_data & ~src;
      default: wr_data = src;
    endcase
  end

  // Counter loads share the modified value
  assign ctr_load_data      = wr_data;
  assign mcycle_load_low    = wr_en && addr == MCYCLE;
  assign mcycle_load_high   = wr_en && addr == MCYCLEH;
  assign minstret_load_low  = wr_en && addr == MINSTRET;
  assign minstret_load_high = wr_en && addr == MINSTRETH;

  // ==============================
  // Registers and trap handling
  // ==============================
  // Enables and mtvec, CSR write wins over a trap
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      msie         <= 1'b0;
      mtie         <= 1'b0;
      meie         <= 1'b0;
      mtvec_base   <= BOOT_ADDR[31:2];
    end else if (wr_en) begin
      case (addr)
        MSTATUS: begin
          mstatus_mie  <= wr_data[3];
          mstatus_mpie <= wr_data[7];
        end
        MIE: begin
          msie <= wr_data[3];
          mtie <= wr_data[7];
          meie <= wr_data[11];
        end
        MTVEC:   mtvec_base <= wr_data[31:2];
        default: ;
      endcase
    end else if (activate_trap) begin
      // Push mie onto the one-deep stack
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
    end else if (return_trap) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end
  end

  assign global_ie = mstatus_mie;

  // Trap data registers
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (addr)
        MSCRATCH: mscratch <= wr_data;
        // Word aligned, IALIGN is 32
        MEPC:     mepc <= {wr_data[31:2], 2'b00};
        MCAUSE:   mcause <= wr_data;
        MTVAL:    mtval <= wr_data;
        default:  ;
      endcase
    end else if (activate_trap) begin
      mepc   <= {pc[31:2], 2'b00};
      mcause <= trap_cause;
      mtval  <= trap_value;
    end
  end

  // Jump pulse one cycle after the request
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) trap_jump <= 1'b0;
    else trap_jump <= activate_trap || return_trap;
  end

  // Handler on entry, saved pc on return
  always_ff @(posedge clk) begin
    if (activate_trap) trap_handle <= {mtvec_base, MTVEC_DIRECT};
    else if (return_trap) trap_handle <= mepc;
  end

endmodule

`default_nettype wire

// File: logic/mcsr_top.sv
// CSR block top level. Counter options come from the params header;
// the request inputs must be held until csr_rdy.
`timescale 1ns/1ps
`default_nettype none

module mcsr_top
  import mcsr_pkg::*;
(
  input  logic        clk,
  input  logic        rstz,
  input  logic [31:0] ir,
  input  logic [31:0] op1,
  input  logic [31:0] pc,
  input  logic        is_csr,
  input  logic        csr_vld,
  output logic        csr_rdy,
  output logic [31:0] csr_data,
  output logic        regwr_csr,
  input  logic        instret,
  input  logic        activate_trap,
  input  logic        return_trap,
  input  logic [31:0] trap_cause,
  input  logic [31:0] trap_value,
  output logic [31:0] trap_handle,
  output logic        trap_jump,
  input  logic        software_interrupt,
  input  logic        timer_interrupt,
  input  logic        external_interrupt,
  output logic        core_interrupt,
  output irq_cause_e  core_interrupt_cause
);

  // Interrupt unit links
  logic [2:0]  mip;
  logic        global_ie;
  logic        msie;
  logic        mtie;
  logic        meie;
  // Counter links
  logic [63:0] mcycle;
  logic        mcycle_vld;
  logic [63:0] minstret;
  logic        minstret_vld;
  logic [31:0] ctr_load_data;
  logic        mcycle_load_low;
  logic        mcycle_load_high;
  logic        minstret_load_low;
  logic        minstret_load_high;

  // ==============================
  // CSR file and interrupt unit
  // ==============================
  mcsr_file csr_file (
    .clk               (clk),
    .rstz              (rstz),
    .ir                (ir),
    .op1               (op1),
    .pc                (pc),
    .is_csr            (is_csr),
    .csr_vld           (csr_vld),
    .csr_rdy           (csr_rdy),
    .csr_data          (csr_data),
    .regwr_csr         (regwr_csr),
    .activate_trap     (activate_trap),
    .return_trap       (return_trap),
    .trap_cause        (trap_cause),
    .trap_value        (trap_value),
    .trap_handle       (trap_handle),
    .trap_jump         (trap_jump),
    .mip               (mip),
    .global_ie         (global_ie),
    .msie              (msie),
    .mtie              (mtie),
    .meie              (meie),
    .mcycle            (mcycle),
    .mcycle_vld        (mcycle_vld),
    .minstret          (minstret),
    .minstret_vld      (minstret_vld),
    .ctr_load_data     (ctr_load_data),
    .mcycle_load_low   (mcycle_load_low),
    .mcycle_load_high  (mcycle_load_high),
    .minstret_load_low (minstret_load_low),
    .minstret_load_high(minstret_load_high)
  );

  mcsr_irq irq_unit (
    .clk                 (clk),
    .rstz                (rstz),
    .software_interrupt  (software_interrupt),
    .timer_interrupt     (timer_interrupt),
    .external_interrupt  (external_interrupt),
    .global_ie           (global_ie),
    .msie                (msie),
    .mtie                (mtie),
    .meie                (meie),
    .mip                 (mip),
    .core_interrupt      (core_interrupt),
    .core_interrupt_cause(core_interrupt_cause)
  );

  // ==============================
  // Performance counters
  // ==============================
  // Free-running cycle count
  mcsr_counter64 mcycle_ctr (
    .clk      (clk),
    .rstz     (rstz),
    .incr     (1'b1),
    .load_data(ctr_load_data),
    .load_low (mcycle_load_low),
    .load_high(mcycle_load_high),
    .count    (mcycle),
    .count_vld(mcycle_vld)
  );

  // Retired instructions
  mcsr_counter64 minstret_ctr (
    .clk      (clk),
    .rstz     (rstz),
    .incr     (instret),
    .load_data(ctr_load_data),
    .load_low (minstret_load_low),
    .load_high(minstret_load_high),
    .count    (minstret),
    .count_vld(minstret_vld)
  );

endmodule

`default_nettype wire

// File: test/mcsr_props.sv
// Handshake, trap pulse and interrupt gating properties. Attached to
// mcsr_top, reaches its internal mip and global_ie wires.
`timescale 1ns/1ps
`default_nettype none

module mcsr_props (
  input logic       clk,
  input logic       rstz,
  input logic       csr_rdy,
  input logic       activate_trap,
  input logic       return_trap,
  input logic       trap_jump,
  input logic       global_ie,
  input logic [2:0] mip,
  input logic       core_interrupt
);

  // csr_rdy is a single-cycle pulse
  rdy_pulse: assert property (@(posedge clk) disable iff (!rstz)
    csr_rdy |=> !csr_rdy)
    else $error("csr_rdy stayed high for two cycles");

  // Trap request gives trap_jump one cycle later
  jump_after_trap: assert property (@(posedge clk) disable iff (!rstz)
    (activate_trap || return_trap) |=> trap_jump)
    else $error("trap_jump missing after a trap request");

  // And never without a request
  jump_has_cause: assert property (@(posedge clk) disable iff (!rstz)
    trap_jump |-> $past(activate_trap || return_trap))
    else $error("trap_jump without a trap request");

  // Globally off, so nothing pends and the core flag stays low after
  irq_quiet: assert property (@(posedge clk) disable iff (!rstz)
    !global_ie |=> (mip == 3'b000) ##1 !core_interrupt)
    else $error("core_interrupt high with mie clear and nothing pending");

endmodule

bind mcsr_top mcsr_props props_i (
  .clk           (clk),
  .rstz          (rstz),
  .csr_rdy       (csr_rdy),
  .activate_trap (activate_trap),
  .return_trap   (return_trap),
  .trap_jump     (trap_jump),
  .global_ie     (global_ie),
  .mip           (mip),
  .core_interrupt(core_interrupt)
);

`default_nettype wire

// File: test/mcsr_tb.sv
// Self-checking testbench for the CSR block. Assumes both counter options
// are on and that interrupt sources stay low outside the interrupt phase.
`timescale 1ns/1ps
`include "mcsr_params.svh"
`default_nettype none

module mcsr_tb
  import mcsr_pkg::*;
();

  localparam int N_RAND     = 200;
  localparam int N_TRAP     = 12;
  localparam int N_IRQ      = 24;
  localparam int N_CTR      = 40;
  // Reset reads and init writes, then every planned CSR access or trap
  localparam int N_OPS      = 8 + N_RAND + 8 * N_TRAP + 4 * N_IRQ + 3 * N_CTR;
  localparam int MAX_CYCLES = 40 * N_OPS + 200;
  localparam int RDY_WAIT   = 8;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // DUT ports
  logic        clk = 1'b0;
  logic        rstz;
  logic [31:0] ir;
  logic [31:0] op1;
  logic [31:0] pc;
  logic        is_csr;
  logic        csr_vld;
  logic        csr_rdy;
  logic [31:0] csr_data;
  logic        regwr_csr;
  logic        instret;
  logic        activate_trap;
  logic        return_trap;
  logic [31:0] trap_cause;
  logic [31:0] trap_value;
  logic [31:0] trap_handle;
  logic        trap_jump;
  logic        software_interrupt;
  logic        timer_interrupt;
  logic        external_interrupt;
  logic        core_interrupt;
  irq_cause_e  core_interrupt_cause;

  // Bookkeeping
  logic [15:0] lfsr;
  int          cycle_count = 0;
  int          rdy_cycle;
  int          value_errors;
  int          other_errors;

  // ==============================
  // Reference model state
  // ==============================
  logic        mdl_mstatus_mie;
  logic        mdl_mpie;
  // {meie, mtie, msie}
  logic [2:0]  mdl_mie;
  logic [2:0]  mdl_mip;
  logic [31:0] mdl_mtvec;
  logic [31:0] mdl_mscratch;
  logic [31:0] mdl_mepc;
  logic [31:0] mdl_mcause;
  logic [31:0] mdl_mtval;
  logic [63:0] mdl_minstret;

  mcsr_top dut_i (.*);

  // 100 ns clock
  always #50 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==============================
  // Random numbers
  // ==============================
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // CSRs touched by the random phase
  function automatic logic [11:0] pick_addr(input logic [31:0] idx);
    case (idx[2:0])
      3'd0:    return MSCRATCH;
      3'd1:    return MTVEC;
      3'd2:    return MEPC;
      3'd3:    return MCAUSE;
      3'd4:    return MTVAL;
      3'd5:    return MIE;
      3'd6:    return MSTATUS;
      default: return MSCRATCH;
    endcase
  endfunction

  // ==============================
  // Model read and write rules
  // ==============================
  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] r;
    r = '0;
    case (addr)
      MSTATUS: begin
        // mpp fixed at machine mode
        r[12:11] = 2'b11;
        r[7]     = mdl_mpie;
        r[3]     = mdl_mstatus_mie;
      end
      MIE: begin
        r[3]  = mdl_mie[0];
        r[7]  = mdl_mie[1];
        r[11] = mdl_mie[2];
      end
      MIP: begin
        r[3]  = mdl_mip[0];
        r[7]  = mdl_mip[1];
        r[11] = mdl_mip[2];
      end
      MTVEC:     r = mdl_mtvec;
      MSCRATCH:  r = mdl_mscratch;
      MEPC:      r = mdl_mepc;
      MCAUSE:    r = mdl_mcause;
      MTVAL:     r = mdl_mtval;
      MINSTRET:  r = mdl_minstret[31:0];
      MINSTRETH: r = mdl_minstret[63:32];
      default:   r = '0;
    endcase
    return r;
  endfunction

  function automatic void model_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
      MSTATUS: begin
        mdl_mstatus_mie = v[3];
        mdl_mpie        = v[7];
      end
      MIE:       mdl_mie = {v[11], v[7], v[3]};
      // Direct mode only, mode bits read zero
      MTVEC:     mdl_mtvec = {v[31:2], 2'b00};
      MSCRATCH:  mdl_mscratch = v;
      // Word aligned
      MEPC:      mdl_mepc = {v[31:2], 2'b00};
      MCAUSE:    mdl_mcause = v;
      MTVAL:     mdl_mtval = v;
      MINSTRET:  mdl_minstret[31:0] = v;
      MINSTRETH: mdl_minstret[63:32] = v;
      default:   ;
    endcase
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_cause(input string name, input irq_cause_e exp, input irq_cause_e act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ==============================
  // CSR requests
  // ==============================
  // Called just after a rising edge with the sequencer idle
  task automatic csr_access(
    input  logic [11:0] addr,
    input  logic [2:0]  funct3,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rd,
    input  logic [31:0] src_reg,
    input  logic        check_old,
    output logic [31:0] old_val
  );
    logic [31:0] exp_old;
    logic [31:0] src;
    logic [31:0] new_val;
    int          waited;
    exp_old = model_read(addr);
    src     = funct3[2] ? {27'b0, rs1} : src_reg;
    ir      = {addr, rs1, funct3, rd, OPC_SYSTEM};
    op1     = src_reg;
    instret = 1'b0;
    is_csr  = 1'b1;
    csr_vld = 1'b1;
    waited  = 0;
    // csr_rdy decodes the state, stable 1 ns after the edge
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!csr_rdy && waited <= RDY_WAIT);
    old_val = csr_data;
    if (!csr_rdy) begin
      other_errors++;
      $display("CSR request to address %h saw no csr_rdy within %0d cycles", addr, RDY_WAIT);
    end else begin
      rdy_cycle = cycle_count;
      if (check_old) begin
        check_word($sformatf("csr_data (csr %h)", addr), exp_old, csr_data);
      end
      check_bit("regwr_csr", rd != 5'd0, regwr_csr);
      case (funct3[1:0])
        2'b10:   new_val = exp_old | src;
        2'b11:   new_val = exp_old & ~src;
        default: new_val = src;
      endcase
      // Set and clear with a zero field leave the CSR alone
      if (funct3[1:0] == 2'b01 || rs1 != 5'd0) begin
        model_write(addr, new_val);
      end
    end
    is_csr  = 1'b0;
    csr_vld = 1'b0;
    // ir and op1 held through the edge that lands the write
    @(posedge clk);
    #1;
  endtask

  // Read only, CSRRS with x0
  task automatic csr_read(input logic [11:0] addr);
    logic [31:0] unused_old;
    csr_access(addr, 3'b010, 5'd0, 5'd1, 32'h0, 1'b1, unused_old);
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
    logic [31:0] unused_old;
    csr_access(addr, 3'b001, 5'd1, 5'd0, val, 1'b1, unused_old);
  endtask

  task automatic random_op();
    logic [11:0] addr;
    logic [1:0]  op;
    logic [31:0] flag;
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic [31:0] src_reg;
    logic [31:0] unused_old;
    addr = pick_addr(rand_bits(3));
    op   = 2'(rand_bits(2));
    // Encoding 00 is not an operation
    if (op == 2'b00) op = CSR_RW;
    flag    = rand_bits(1);
    // Zero fields often, to hit the cancelled set and clear
    rs1     = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
    rd      = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
    src_reg = rand_bits(32);
    csr_access(addr, {flag[0], op}, rs1, rd, src_reg, 1'b1, unused_old);
  endtask

  // ==============================
  // Traps, interrupts, counters
  // ==============================
  task automatic trap_enter();
    logic [31:0] exp_handle;
    pc            = rand_bits(32);
    trap_cause    = rand_bits(32);
    trap_value    = rand_bits(32);
    activate_trap = 1'b1;
    exp_handle    = mdl_mtvec;
    @(posedge clk);
    #1;
    activate_trap = 1'b0;
    check_bit("trap_jump", 1'b1, trap_jump);
    check_word("trap_handle", exp_handle, trap_handle);
    mdl_mepc        = {pc[31:2], 2'b00};
    mdl_mcause      = trap_cause;
    mdl_mtval       = trap_value;
    mdl_mpie        = mdl_mstatus_mie;
    mdl_mstatus_mie = 1'b0;
    @(posedge clk);
    #1;
    check_bit("trap_jump", 1'b0, trap_jump);
  endtask

  task automatic trap_return();
    logic [31:0] exp_handle;
    return_trap = 1'b1;
    exp_handle  = mdl_mepc;
    @(posedge clk);
    #1;
    return_trap = 1'b0;
    check_bit("trap_jump", 1'b1, trap_jump);
    check_word("trap_handle", exp_handle, trap_handle);
    mdl_mstatus_mie = mdl_mpie;
    mdl_mpie        = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic irq_trial();
    logic [2:0]  srcs;
    logic [2:0]  gated;
    irq_cause_e  exp_cause;
    // Random msie, mtie, meie and mstatus
    csr_write(MIE, rand_bits(32) & 32'h0000_0888);
    csr_write(MSTATUS, rand_bits(32));
    srcs               = 3'(rand_bits(3));
    software_interrupt = srcs[0];
    timer_interrupt    = srcs[1];
    external_interrupt = srcs[2];
    // Source to core_interrupt is 2 cycles, hold for 3
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    gated   = srcs & mdl_mie & {3{mdl_mstatus_mie}};
    mdl_mip = gated;
    check_bit("core_interrupt", |gated, core_interrupt);
    if (|gated) begin
      if (gated[2]) exp_cause = EXTERNAL_INTERRUPT;
      else if (gated[0]) exp_cause = SOFTWARE_INTERRUPT;
      else exp_cause = TIMER_INTERRUPT;
      check_cause("core_interrupt_cause", exp_cause, core_interrupt_cause);
    end
    csr_read(MIP);
  endtask

  // Random instret, counted by the model when driven
  task automatic idle_cycles(input int n);
    logic [31:0] r;
    repeat (n) begin
      r            = rand_bits(1);
      instret      = r[0];
      mdl_minstret = mdl_minstret + {63'b0, r[0]};
      @(posedge clk);
      #1;
    end
    instret = 1'b0;
  endtask

  task automatic counter_op();
    logic [31:0] kind;
    logic [31:0] val;
    kind = rand_bits(2);
    val  = rand_bits(32);
    case (kind[1:0])
      2'd0: csr_read(MINSTRET);
      2'd1: csr_read(MINSTRETH);
      // Low half parked near a wrap so the carry gets exercised
      2'd2: csr_write(MINSTRET, {28'hFFF_FFFF, val[3:0]});
      default: csr_write(MINSTRETH, val);
    endcase
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main
    logic [31:0] unused_old;
    logic [31:0] prev_mcycle;
    logic [31:0] cur_mcycle;
    logic [31:0] span;
    int          prev_rdy;
    rstz               = 1'b0;
    ir                 = '0;
    op1                = '0;
    pc                 = '0;
    is_csr             = 1'b0;
    csr_vld            = 1'b0;
    instret            = 1'b0;
    activate_trap      = 1'b0;
    return_trap        = 1'b0;
    trap_cause         = '0;
    trap_value         = '0;
    software_interrupt = 1'b0;
    timer_interrupt    = 1'b0;
    external_interrupt = 1'b0;
    lfsr               = 16'd12;
    value_errors       = 0;
    other_errors       = 0;
    rdy_cycle          = 0;
    mdl_mstatus_mie    = 1'b0;
    mdl_mpie           = 1'b0;
    mdl_mie            = '0;
    mdl_mip            = '0;
    mdl_mtvec          = `MCSR_BOOT_ADDR & 32'hFFFF_FFFC;
    mdl_minstret       = '0;
    repeat (4) @(posedge clk);
    #1;
    rstz = 1'b1;
    @(posedge clk);
    #1;

    // Reset values
    csr_read(MTVEC);
    csr_read(MSTATUS);
    csr_read(MIE);
    csr_read(MIP);

    // Registers without reset get a known value first
    csr_access(MSCRATCH, 3'b001, 5'd1, 5'd0, rand_bits(32), 1'b0, unused_old);
    csr_access(MEPC, 3'b001, 5'd1, 5'd0, rand_bits(32), 1'b0, unused_old);
    csr_access(MCAUSE, 3'b001, 5'd1, 5'd0, rand_bits(32), 1'b0, unused_old);
    csr_access(MTVAL, 3'b001, 5'd1, 5'd0, rand_bits(32), 1'b0, unused_old);

    repeat (N_RAND) random_op();

    // Trap entry, readback, return
    repeat (N_TRAP) begin
      csr_write(MSTATUS, rand_bits(32));
      trap_enter();
      csr_read(MEPC);
      csr_read(MCAUSE);
      csr_read(MTVAL);
      csr_read(MSTATUS);
      trap_return();
      csr_read(MSTATUS);
    end

    repeat (N_IRQ) irq_trial();
    software_interrupt = 1'b0;
    timer_interrupt    = 1'b0;
    external_interrupt = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    mdl_mip = '0;
    csr_read(MIP);

    // Counters, mcycle checked by its step between reads
    csr_access(MCYCLE, 3'b110, 5'd0, 5'd1, 32'h0, 1'b0, prev_mcycle);
    prev_rdy = rdy_cycle;
    repeat (N_CTR) begin
      idle_cycles(1 + rand_bits(2));
      counter_op();
      csr_access(MCYCLE, 3'b110, 5'd0, 5'd1, 32'h0, 1'b0, cur_mcycle);
      span = rdy_cycle - prev_rdy;
      if (cur_mcycle <= prev_mcycle || cur_mcycle - prev_mcycle > span) begin
        other_errors++;
        $display("mcycle moved from %h to %h over %0d cycles, not a valid count step",
                 prev_mcycle, cur_mcycle, span);
      end
      prev_mcycle = cur_mcycle;
      prev_rdy    = rdy_cycle;
    end

    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mcsr.f
+incdir+logic
logic/mcsr_pkg.sv
logic/mcsr_counter64.sv
logic/mcsr_irq.sv
logic/mcsr_file.sv
logic/mcsr_top.sv
test/mcsr_props.sv
test/mcsr_tb.sv

// File: Makefile
# Verilator flow for the CSR block testbench
VERILATOR  ?= verilator
TOP        ?= mcsr_tb
FILELIST   ?= mcsr.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL CHECKS PASSED
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
